/* hw/mem_cfg_pkg.sv */
package mem_cfg_pkg;

    // Data word shared by both banks
    localparam int data_w = 20;

    // Unified address space seen by the requesters
    localparam int addr_w = 10;

    // Set selects the deep bank, clear selects the shallow bank
    localparam int bank_sel_bit = 9;

    // Shallow distributed-RAM bank
    localparam int lutram_aw = 5;
    localparam int lutram_words = 1 << lutram_aw;

    // Deep block-RAM bank
    localparam int bram_aw = 9;
    localparam int bram_words = 1 << bram_aw;

    // Unused bits between the bank flag and the shallow index
    localparam int lutram_pad_w = bank_sel_bit - lutram_aw;

    // Read sample to response, in rdclk cycles
    localparam int rd_latency = 3;

endpackage

/* hw/mem_types_pkg.sv */
package mem_types_pkg;

    // Shallow view of an address
    typedef struct packed {
        logic                                  deep;
        logic [mem_cfg_pkg::lutram_pad_w-1:0]  pad;
        logic [mem_cfg_pkg::lutram_aw-1:0]     idx;
    } lutram_addr_t;

    // Deep view of an address
    typedef struct packed {
        logic                              deep;
        logic [mem_cfg_pkg::bram_aw-1:0]   idx;
    } bram_addr_t;

    // One address word, decoded per bank
    typedef union packed {
        lutram_addr_t  lutram;
        bram_addr_t    bram;
    } mem_addr_u;

    typedef struct packed {
        logic                             en;
        mem_addr_u                        addr;
        logic [mem_cfg_pkg::data_w-1:0]   data;
    } wr_req_t;

    typedef struct packed {
        logic       en;
        mem_addr_u  addr;
    } rd_req_t;

    // Merged read response, valid for one cycle per read
    typedef struct packed {
        logic                             valid;
        logic [mem_cfg_pkg::data_w-1:0]   data;
    } rd_rsp_t;

endpackage

/* hw/lutram_bank.sv */
`timescale 1ns/10ps

module lutram_bank (
    input  logic                               rdclk,

    input  logic                               wr_en,
    input  logic [mem_cfg_pkg::lutram_aw-1:0]  wr_idx,
    input  logic [mem_cfg_pkg::data_w-1:0]     wr_data,

    input  logic [mem_cfg_pkg::lutram_aw-1:0]  rd_idx,
    output logic [mem_cfg_pkg::data_w-1:0]     rd_data
);

    logic [mem_cfg_pkg::data_w-1:0]     mem [mem_cfg_pkg::lutram_words];

    logic                               wr_en_q;
    logic [mem_cfg_pkg::lutram_aw-1:0]  wr_idx_q;
    logic [mem_cfg_pkg::data_w-1:0]     wr_data_q;

    logic [mem_cfg_pkg::lutram_aw-1:0]  rd_idx_q;
    logic [mem_cfg_pkg::data_w-1:0]     rd_data_q;
    logic [mem_cfg_pkg::data_w-1:0]     rd_word;

    // Write request is registered, array updates on the next edge
    always_ff @(posedge rdclk) begin
        if (wr_en_q) begin
            mem[wr_idx_q] <= wr_data_q;
        end
        wr_en_q   <= wr_en;
        wr_idx_q  <= wr_idx;
        wr_data_q <= wr_data;
    end

    // Async array read behind the address register
    assign rd_word = mem[rd_idx_q];

    always_ff @(posedge rdclk) begin
        rd_idx_q  <= rd_idx;
        rd_data_q <= rd_word;
    end

    assign rd_data = rd_data_q;

endmodule

/* hw/bram_bank.sv */
`timescale 1ns/10ps

module bram_bank (
    input  logic                             rdclk,

    input  logic                             wr_en,
    input  logic [mem_cfg_pkg::bram_aw-1:0]  wr_idx,
    input  logic [mem_cfg_pkg::data_w-1:0]   wr_data,

    input  logic                             rd_en,
    input  logic [mem_cfg_pkg::bram_aw-1:0]  rd_idx,
    output logic [mem_cfg_pkg::data_w-1:0]   rd_data
);

    logic [mem_cfg_pkg::data_w-1:0]   mem [mem_cfg_pkg::bram_words];

    logic                             wr_en_q;
    logic [mem_cfg_pkg::bram_aw-1:0]  wr_idx_q;
    logic [mem_cfg_pkg::data_w-1:0]   wr_data_q;

    logic                             rd_en_q;
    logic [mem_cfg_pkg::bram_aw-1:0]  rd_idx_q;
    logic [mem_cfg_pkg::data_w-1:0]   rd_word;

    // Output pipeline, s1 then s2
    logic [mem_cfg_pkg::data_w-1:0]   rd_s1_q;
    logic [mem_cfg_pkg::data_w-1:0]   rd_s2_q;

    always_ff @(posedge rdclk) begin
        if (wr_en_q) begin
            mem[wr_idx_q] <= wr_data_q;
        end
        wr_en_q   <= wr_en;
        wr_idx_q  <= wr_idx;
        wr_data_q <= wr_data;
    end

    always_ff @(posedge rdclk) begin
        rd_en_q  <= rd_en;
        rd_idx_q <= rd_idx;
    end

    assign rd_word = mem[rd_idx_q];

    // First stage holds its last word when no read is pending
    always_ff @(posedge rdclk) begin
        if (rd_en_q) begin
            rd_s1_q <= rd_word;
        end
    end

    always_ff @(posedge rdclk) begin
        rd_s2_q <= rd_s1_q;
    end

    assign rd_data = rd_s2_q;

endmodule

/* hw/bank_read_merge.sv */
`timescale 1ns/10ps

module bank_read_merge (
    input  logic                            rdclk,
    input  logic                            rst_n,

    input  logic                            lutram_rd,
    input  logic                            bram_rd,
    input  logic [mem_cfg_pkg::data_w-1:0]  lutram_data,
    input  logic [mem_cfg_pkg::data_w-1:0]  bram_data,

    output mem_types_pkg::rd_rsp_t          rsp
);

    localparam int depth = mem_cfg_pkg::rd_latency;

    // Shallow bank is one cycle faster than the deep one
    logic [mem_cfg_pkg::data_w-1:0]  lutram_data_q;

    // Strobe history, bit 0 is the newest read
    logic [depth-1:0]                lutram_pipe_q;
    logic [depth-1:0]                bram_pipe_q;
    logic                            lutram_hit;
    logic                            bram_hit;

    mem_types_pkg::rd_rsp_t          rsp_q;

    always_ff @(posedge rdclk) begin
        lutram_data_q <= lutram_data;
    end

    always_ff @(posedge rdclk) begin
        if (!rst_n) begin
            lutram_pipe_q <= '0;
            bram_pipe_q   <= '0;
        end else begin
            lutram_pipe_q <= {lutram_pipe_q[depth-2:0], lutram_rd};
            bram_pipe_q   <= {bram_pipe_q[depth-2:0], bram_rd};
        end
    end

    assign lutram_hit = lutram_pipe_q[depth-1];
    assign bram_hit   = bram_pipe_q[depth-1];

    // At most one of the hits is set, deep bank takes the mux when it is
    always_ff @(posedge rdclk) begin
        rsp_q.data <= bram_hit ? bram_data : lutram_data_q;
        if (!rst_n) begin
            rsp_q.valid <= 1'b0;
        end else begin
            rsp_q.valid <= lutram_hit | bram_hit;
        end
    end

    assign rsp = rsp_q;

endmodule

/* hw/split_mem_top.sv */
`timescale 1ns/10ps

module split_mem_top (
    input  logic                     rdclk,
    input  logic                     rst_n,

    input  mem_types_pkg::wr_req_t   wr,
    input  mem_types_pkg::rd_req_t   rd,

    output mem_types_pkg::rd_rsp_t   rsp
);

    logic                            wr_deep;
    logic                            rd_deep;

    logic                            lutram_wr;
    logic                            bram_wr;
    logic                            lutram_rd;
    logic                            bram_rd;

    logic [mem_cfg_pkg::data_w-1:0]  lutram_data;
    logic [mem_cfg_pkg::data_w-1:0]  bram_data;

    // Bank flag of each request
    assign wr_deep = wr.addr[mem_cfg_pkg::bank_sel_bit];
    assign rd_deep = rd.addr[mem_cfg_pkg::bank_sel_bit];

    assign lutram_wr = wr.en & ~wr_deep;
    assign bram_wr   = wr.en & wr_deep;

    // One strobe per read, never both
    assign lutram_rd = rd.en & ~rd_deep;
    assign bram_rd   = rd.en & rd_deep;

    // Shallow index drops bits 5 to 8, so those addresses alias
    lutram_bank lutram_i (
        .rdclk   (rdclk),
        .wr_en   (lutram_wr),
        .wr_idx  (wr.addr.lutram.idx),
        .wr_data (wr.data),
        .rd_idx  (rd.addr.lutram.idx),
        .rd_data (lutram_data)
    );

    bram_bank bram_i (
        .rdclk   (rdclk),
        .wr_en   (bram_wr),
        .wr_idx  (wr.addr.bram.idx),
        .wr_data (wr.data),
        .rd_en   (bram_rd),
        .rd_idx  (rd.addr.bram.idx),
        .rd_data (bram_data)
    );

    bank_read_merge merge_i (
        .rdclk       (rdclk),
        .rst_n       (rst_n),
        .lutram_rd   (lutram_rd),
        .bram_rd     (bram_rd),
        .lutram_data (lutram_data),
        .bram_data   (bram_data),
        .rsp         (rsp)
    );

endmodule

/* tb/split_mem_tb.sv */
`timescale 1ns/10ps

module split_mem_tb;

    typedef logic [mem_cfg_pkg::addr_w-1:0] addr_t;
    typedef logic [mem_cfg_pkg::data_w-1:0] data_t;

    // One predicted response and the edge where rsp is checked for it
    typedef struct packed {
        int unsigned  due;
        data_t        data;
    } exp_rd_t;

    localparam int clk_half      = 10;
    localparam int reset_cycles  = 16;
    localparam int settle_cycles = 4;
    localparam int dir_words     = 8;
    localparam int alias_words   = 4;
    localparam int rand_cycles   = 200;
    localparam int drain_cycles  = mem_cfg_pkg::rd_latency + 4;

    // Directed blocks are writes, two idle cycles, then reads
    localparam int stim_cycles = settle_cycles + 2 * (2 * dir_words + 2)
                               + (4 * alias_words + 2) + rand_cycles + drain_cycles;
    localparam int watchdog_ns = (reset_cycles + stim_cycles + mem_cfg_pkg::rd_latency + 50)
                               * 2 * clk_half;

    logic                    rdclk;
    logic                    rst_n;
    mem_types_pkg::wr_req_t  wr;
    mem_types_pkg::rd_req_t  rd;
    mem_types_pkg::rd_rsp_t  rsp;

    integer                  seed;
    int unsigned             cycle = 0;

    logic                    exp_valid = 1'b0;
    data_t                   exp_data = '0;
    exp_rd_t                 exp_q [$];

    // Reference contents and last write edge, keyed by the word an address selects
    data_t                   model [int];
    int unsigned             last_wr [int];
    int                      written [$];

    split_mem_top dut_i (
        .rdclk (rdclk),
        .rst_n (rst_n),
        .wr    (wr),
        .rd    (rd),
        .rsp   (rsp)
    );

    initial rdclk = 1'b0;
    always #(clk_half) rdclk = ~rdclk;

    // Number of rising edges seen so far
    always @(posedge rdclk) begin
        cycle <= cycle + 1;
    end

    // Expected response for the coming rising edge
    always @(negedge rdclk) begin
        if (exp_q.size() != 0 && exp_q[0].due == cycle + 1) begin
            exp_valid <= 1'b1;
            exp_data  <= exp_q[0].data;
            void'(exp_q.pop_front());
        end else begin
            exp_valid <= 1'b0;
        end
    end

    valid_check: assert property (@(posedge rdclk) cycle >= 1 |-> rsp.valid == exp_valid)
        else stop_on_error($sformatf("Fail rsp.valid expected %h got %h",
                                     exp_valid, $sampled(rsp.valid)));

    data_check: assert property (@(posedge rdclk) exp_valid |-> rsp.data == exp_data)
        else stop_on_error($sformatf("Fail rsp.data expected %h got %h",
                                     exp_data, $sampled(rsp.data)));

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Shallow words ignore bits 5 to 8 of the address
    function automatic int norm_key(input addr_t addr);
        addr_t key;
        key = addr;
        if (!addr[mem_cfg_pkg::bank_sel_bit]) begin
            key[mem_cfg_pkg::bank_sel_bit-1:mem_cfg_pkg::lutram_aw] = '0;
        end
        return int'(key);
    endfunction

    // Called at a falling edge, the request is sampled at the next rising edge
    task automatic apply(input logic wr_en, input addr_t wr_addr, input data_t wr_data,
                         input logic rd_en, input addr_t rd_addr);
        exp_rd_t      e;
        int unsigned  edge_n;
        int           key;
        edge_n = cycle + 1;
        if (rd_en) begin
            e.due  = edge_n + mem_cfg_pkg::rd_latency + 1;
            e.data = model[norm_key(rd_addr)];
            exp_q.push_back(e);
        end
        if (wr_en) begin
            key = norm_key(wr_addr);
            if (!model.exists(key)) begin
                written.push_back(key);
            end
            model[key]   = wr_data;
            last_wr[key] = edge_n;
        end
        wr.en   = wr_en;
        wr.addr = wr_addr;
        wr.data = wr_data;
        rd.en   = rd_en;
        rd.addr = rd_addr;
    endtask

    task automatic drive(input logic wr_en, input addr_t wr_addr, input data_t wr_data,
                         input logic rd_en, input addr_t rd_addr);
        @(negedge rdclk);
        apply(wr_en, wr_addr, wr_data, rd_en, rd_addr);
    endtask

    task automatic idle(input int n);
        repeat (n) drive(1'b0, '0, '0, 1'b0, '0);
    endtask

    // Fill one region, then read it back with back-to-back reads
    task automatic directed_block(input logic deep);
        addr_t  addrs [dir_words];
        for (int i = 0; i < dir_words; i++) begin
            addrs[i] = {deep, 9'($random(seed))};
            drive(1'b1, addrs[i], data_t'($random(seed)), 1'b0, '0);
        end
        idle(2);
        for (int i = 0; i < dir_words; i++) begin
            drive(1'b0, '0, '0, 1'b1, addrs[i]);
        end
    endtask

    // Same index in both regions with different data
    task automatic alias_block();
        logic [mem_cfg_pkg::lutram_aw-1:0]     idx [alias_words];
        logic [mem_cfg_pkg::lutram_pad_w-1:0]  pad [alias_words];
        data_t                                 d;
        for (int i = 0; i < alias_words; i++) begin
            idx[i] = 5'(7 * i + 3);
            pad[i] = 4'($random(seed));
            d      = data_t'($random(seed));
            drive(1'b1, {1'b0, pad[i], idx[i]}, d, 1'b0, '0);
            drive(1'b1, {1'b1, 4'b0, idx[i]}, ~d, 1'b0, '0);
        end
        idle(2);
        // Flipped pad bits still reach the same shallow word
        for (int i = 0; i < alias_words; i++) begin
            drive(1'b0, '0, '0, 1'b1, {1'b0, ~pad[i], idx[i]});
            drive(1'b0, '0, '0, 1'b1, {1'b1, 4'b0, idx[i]});
        end
    endtask

    task automatic random_block();
        logic   do_wr;
        logic   do_rd;
        addr_t  wa;
        addr_t  ra;
        data_t  wd;
        for (int n = 0; n < rand_cycles; n++) begin
            @(negedge rdclk);
            do_rd = 1'b0;
            ra    = '0;
            if (written.size() != 0 && ($random(seed) & 3) != 0) begin
                ra = addr_t'(written[$unsigned($random(seed)) % written.size()]);
                if (!ra[mem_cfg_pkg::bank_sel_bit]) begin
                    ra[8:5] = 4'($random(seed));
                end
                // Too soon after a write to this word, skip the read
                do_rd = (last_wr[norm_key(ra)] + 2 <= cycle + 1);
            end
            do_wr = 1'($random(seed));
            wa    = addr_t'($random(seed));
            wd    = data_t'($random(seed));
            if (do_rd && norm_key(wa) == norm_key(ra)) begin
                do_wr = 1'b0;
            end
            apply(do_wr, wa, wd, do_rd, ra);
        end
    endtask

    initial begin
        seed  = 41689;
        rst_n = 1'b0;
        wr    = '0;
        rd    = '0;
        repeat (reset_cycles) @(negedge rdclk);
        rst_n = 1'b1;
        idle(settle_cycles);
        directed_block(1'b0);
        directed_block(1'b1);
        alias_block();
        random_block();
        idle(drain_cycles);
        if (exp_q.size() != 0) begin
            stop_on_error("some predicted read responses never came due");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    initial begin
        #(watchdog_ns);
        stop_on_error("timeout because the stimulus did not complete in the expected time");
    end

endmodule

/* vlog.f */
hw/mem_cfg_pkg.sv
hw/mem_types_pkg.sv
hw/lutram_bank.sv
hw/bram_bank.sv
hw/bank_read_merge.sv
hw/split_mem_top.sv
tb/split_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log for the pass message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
    --top-module split_mem_tb \
    -f vlog.f \
    -o split_mem_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/split_mem_sim > sim.log 2>&1
cat sim.log

grep -q "^TEST PASS$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
